// File: Makefile
# Verilator build and run of the read-data FIFO testbench

TOP             ?= tb_rdf
SEED            ?= 32'hf1cffba1
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

FLIST := project.f
SRCS  := $(filter %.sv,$(shell cat $(FLIST)))
BIN   := obj_dir/V$(TOP)
LOG   := sim.log

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -GSEED="$(SEED)" -f $(FLIST)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
	    echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: project.f
rdf_pkg.sv
rdf_ptr_ctrl.sv
rdf_ram.sv
rdf_cfg_regs.sv
rdf_top.sv
tb_rdf.sv

// File: rdf_cfg_regs.sv
`timescale 1ns/1ps

module rdf_cfg_regs #(
    parameter int DEPTH_W = rdf_pkg::DEPTH_W
) (
    input  logic                   rclk,
    input  logic                   rrst,
    // register access
    input  logic                   reg_we,
    input  rdf_pkg::rdf_reg_addr_e reg_addr,
    input  logic [DEPTH_W:0]       reg_wdata,
    output logic [DEPTH_W:0]       reg_rdata,   // combinational readback
    // status and thresholds
    input  logic                   rd_underflow,
    output rdf_pkg::rdf_cfg_t      cfg
);

    import rdf_pkg::*;

    // reset thresholds, 14 and 2 at depth 16
    localparam int AF_RST = 2 ** DEPTH_W - 2;
    localparam int AE_RST = 2;

    logic [DEPTH_W:0] af_q;   // almost-full threshold
    logic [DEPTH_W:0] ae_q;   // almost-empty threshold
    logic             udf_q;  // sticky underflow
    logic             wr_af;
    logic             wr_ae;
    logic             wr_st;

    // write decode
    assign wr_af = reg_we && (reg_addr == REG_AF);
    assign wr_ae = reg_we && (reg_addr == REG_AE);
    assign wr_st = reg_we && (reg_addr == REG_STATUS);

    // *******************************************************************
    // registers
    // *******************************************************************

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            af_q  <= AF_RST[DEPTH_W:0];
            ae_q  <= AE_RST[DEPTH_W:0];
            udf_q <= 1'b0;
        end
        else
        begin
            if (wr_af)
                af_q <= reg_wdata;
            if (wr_ae)
                ae_q <= reg_wdata;
            if (wr_st)
                udf_q <= 1'b0;         // any status write clears
            else if (rd_underflow)
                udf_q <= 1'b1;
        end
    end

    // readback mux
    always_comb
    begin
        reg_rdata = '0;
        case (reg_addr)
            REG_AF:     reg_rdata = af_q;
            REG_AE:     reg_rdata = ae_q;
            REG_STATUS: reg_rdata[0] = udf_q;
            default:    reg_rdata = '0;
        endcase
    end

    assign cfg.af_num = rdf_level_t'(af_q);
    assign cfg.ae_num = rdf_level_t'(ae_q);

    // host must present a decoded address with every write
    a_reg_addr_known: assert property (@(posedge rclk) disable iff (rrst)
        reg_we |-> (!$isunknown(reg_addr) &&
                    (reg_addr inside {REG_AF, REG_AE, REG_STATUS})))
        else $error("reg write to bad address %0h", reg_addr);

endmodule

// File: rdf_pkg.sv
package rdf_pkg;

    // *******************************************************************
    // sizing defaults
    // *******************************************************************

    // depth width, 16 entries by default
    parameter int DEPTH_W = 4;
    parameter int DATA_W  = 32;   // read data word

    // *******************************************************************
    // vector types
    // *******************************************************************

    typedef logic [DEPTH_W:0]   rdf_ptr_t;    // pointer plus wrap bit
    typedef logic [DEPTH_W:0]   rdf_level_t;  // fill level 0..2**DEPTH_W
    typedef logic [DEPTH_W-1:0] rdf_addr_t;   // storage index
    typedef logic [DATA_W-1:0]  rdf_data_t;   // one stored word

    // thresholds driven from the register block
    typedef struct packed {
        rdf_level_t af_num;   // almost full at or above this
        rdf_level_t ae_num;   // almost empty at or below this
    } rdf_cfg_t;

    // register map of the rclk side block
    typedef enum logic [1:0] {
        REG_AF     = 2'd0,    // almost-full threshold
        REG_AE     = 2'd1,    // almost-empty threshold
        REG_STATUS = 2'd2     // bit 0 sticky underflow
    } rdf_reg_addr_e;

endpackage

// File: rdf_ptr_ctrl.sv
`timescale 1ns/1ps

module rdf_ptr_ctrl #(
    parameter int DEPTH_W = rdf_pkg::DEPTH_W
) (
    // write domain
    input  logic               wclk,
    input  logic               wrst,
    input  logic               w_en,
    output logic               wr_go,        // accepted write
    output logic [DEPTH_W-1:0] waddr,
    output logic               wfull,
    output logic               almost_full,
    output logic [DEPTH_W:0]   wr_level,
    // read domain
    input  logic               rclk,
    input  logic               rrst,
    input  logic               r_en,
    output logic               rd_go,        // accepted read
    output logic [DEPTH_W-1:0] raddr,
    output logic               rempty,
    output logic               almost_empty,
    output logic [DEPTH_W:0]   rd_level,
    output logic               rd_underflow, // read attempt while empty
    // thresholds, quasi static
    input  rdf_pkg::rdf_cfg_t  cfg
);

    typedef logic [DEPTH_W:0] ptr_t;   // msb is the wrap bit

    // write side pointers
    ptr_t wbin;       // current binary
    ptr_t wbnext;     // next binary
    ptr_t wgnext;     // next gray
    ptr_t wptr;       // registered gray, crosses to rclk
    ptr_t wrptr1;     // read ptr, 1st sync flop
    ptr_t wrptr2;     // read ptr, 2nd sync flop
    ptr_t wrptr2_b;   // synced read ptr in binary

    // read side pointers
    ptr_t rbin;
    ptr_t rbnext;
    ptr_t rgnext;
    ptr_t rptr;       // registered gray, crosses to wclk
    ptr_t rwptr1;
    ptr_t rwptr2;
    ptr_t rwptr2_b;

    // gray back to binary, msb down
    function automatic ptr_t gray2bin(input ptr_t g);
        ptr_t b;
        b[DEPTH_W] = g[DEPTH_W];
        for (int i = DEPTH_W - 1; i >= 0; i--)
        begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // *******************************************************************
    // write domain
    // *******************************************************************

    assign wr_go  = w_en & ~wfull;              // drop writes at full
    assign wbnext = wbin + ptr_t'(wr_go);
    assign wgnext = (wbnext >> 1) ^ wbnext;     // bin to gray
    assign waddr  = wbin[DEPTH_W-1:0];

    always_ff @(posedge wclk or posedge wrst)
    begin
        if (wrst)
        begin
            wbin <= '0;
            wptr <= '0;
        end
        else
        begin
            wbin <= wbnext;
            wptr <= wgnext;
        end
    end

    // read pointer into wclk, two flops
    always_ff @(posedge wclk or posedge wrst)
    begin
        if (wrst)
            {wrptr2, wrptr1} <= '0;
        else
            {wrptr2, wrptr1} <= {wrptr1, rptr};
    end

    assign wrptr2_b = gray2bin(wrptr2);

    // full from next ptr so it rises with the last store
    always_ff @(posedge wclk or posedge wrst)
    begin
        if (wrst)
        begin
            wfull    <= 1'b0;
            wr_level <= '0;
        end
        else
        begin
            wfull    <= (wbnext[DEPTH_W] != wrptr2_b[DEPTH_W]) &&
                        (wbnext[DEPTH_W-1:0] == wrptr2_b[DEPTH_W-1:0]);
            wr_level <= wbnext - wrptr2_b;    // modulo diff covers the wrap
        end
    end

    assign almost_full = (wr_level >= cfg.af_num);

    // *******************************************************************
    // read domain
    // *******************************************************************

    assign rd_go        = r_en & ~rempty;       // ignore reads at empty
    assign rd_underflow = r_en & rempty;
    assign rbnext       = rbin + ptr_t'(rd_go);
    assign rgnext       = (rbnext >> 1) ^ rbnext;
    assign raddr        = rbin[DEPTH_W-1:0];

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            rbin <= '0;
            rptr <= '0;
        end
        else
        begin
            rbin <= rbnext;
            rptr <= rgnext;
        end
    end

    // write pointer into rclk
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
            {rwptr2, rwptr1} <= '0;
        else
            {rwptr2, rwptr1} <= {rwptr1, wptr};
    end

    assign rwptr2_b = gray2bin(rwptr2);

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            rempty   <= 1'b1;   // empty out of reset
            rd_level <= '0;
        end
        else
        begin
            rempty   <= (rbnext == rwptr2_b);
            rd_level <= rwptr2_b - rbnext;
        end
    end

    assign almost_empty = (rd_level <= cfg.ae_num);

    // *******************************************************************
    // checks
    // *******************************************************************

    // write pointer never more than one depth past the synced read ptr
    a_no_wr_at_full: assert property (@(posedge wclk) disable iff (wrst)
        ptr_t'(wbin - wrptr2_b) <= ptr_t'(2 ** DEPTH_W))
        else $error("wbin advanced past a full FIFO");

    // read pointer never passes the synced write ptr
    a_no_rd_at_empty: assert property (@(posedge rclk) disable iff (rrst)
        ptr_t'(rwptr2_b - rbin) <= ptr_t'(2 ** DEPTH_W))
        else $error("rbin advanced past an empty FIFO");

endmodule

// File: rdf_ram.sv
`timescale 1ns/1ps

module rdf_ram #(
    parameter int DEPTH_W = rdf_pkg::DEPTH_W,
    parameter int DATA_W  = rdf_pkg::DATA_W
) (
    // write port, wclk
    input  logic               wclk,
    input  logic               wr_go,
    input  logic [DEPTH_W-1:0] waddr,
    input  logic [DATA_W-1:0]  wdata,
    // read port, rclk
    input  logic               rclk,
    input  logic               rrst,
    input  logic               rd_go,
    input  logic [DEPTH_W-1:0] raddr,
    output logic [DATA_W-1:0]  rdata,
    output logic               rvalid
);

    localparam int DEPTH = 2 ** DEPTH_W;

    logic [DATA_W-1:0] mem [DEPTH];   // storage array

    // *******************************************************************
    // write port
    // *******************************************************************

    always_ff @(posedge wclk)
    begin
        if (wr_go)
            mem[waddr] <= wdata;
    end

    // *******************************************************************
    // read port, one cycle latency
    // *******************************************************************

    always_ff @(posedge rclk)
    begin
        if (rd_go)
            rdata <= mem[raddr];   // held until the next read
    end

    // one pulse per accepted read
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
            rvalid <= 1'b0;
        else
            rvalid <= rd_go;
    end

endmodule

// File: rdf_top.sv
`timescale 1ns/1ps

module rdf_top #(
    parameter int DEPTH_W = rdf_pkg::DEPTH_W,
    parameter int DATA_W  = rdf_pkg::DATA_W
) (
    // memory side, wclk
    input  logic                   wclk,
    input  logic                   wrst,
    input  logic                   w_en,
    input  logic [DATA_W-1:0]      wdata,
    output logic                   wfull,
    output logic                   almost_full,
    output logic [DEPTH_W:0]       wr_level,
    // user side, rclk
    input  logic                   rclk,
    input  logic                   rrst,
    input  logic                   r_en,
    output logic [DATA_W-1:0]      rdata,
    output logic                   rvalid,
    output logic                   rempty,
    output logic                   almost_empty,
    output logic [DEPTH_W:0]       rd_level,
    // register access, rclk
    input  logic                   reg_we,
    input  rdf_pkg::rdf_reg_addr_e reg_addr,
    input  logic [DEPTH_W:0]       reg_wdata,
    output logic [DEPTH_W:0]       reg_rdata
);

    import rdf_pkg::*;

    logic               wr_go;         // gated write enable
    logic [DEPTH_W-1:0] waddr;
    logic               rd_go;         // gated read enable
    logic [DEPTH_W-1:0] raddr;
    logic               rd_underflow;
    rdf_cfg_t           cfg;           // thresholds to the controller

    // *******************************************************************
    // pointer control
    // *******************************************************************

    rdf_ptr_ctrl #(
        .DEPTH_W      (DEPTH_W)
    ) u_ptr_ctrl (
        .wclk         (wclk),
        .wrst         (wrst),
        .w_en         (w_en),
        .wr_go        (wr_go),
        .waddr        (waddr),
        .wfull        (wfull),
        .almost_full  (almost_full),
        .wr_level     (wr_level),
        .rclk         (rclk),
        .rrst         (rrst),
        .r_en         (r_en),
        .rd_go        (rd_go),
        .raddr        (raddr),
        .rempty       (rempty),
        .almost_empty (almost_empty),
        .rd_level     (rd_level),
        .rd_underflow (rd_underflow),
        .cfg          (cfg)
    );

    // storage
    rdf_ram #(
        .DEPTH_W (DEPTH_W),
        .DATA_W  (DATA_W)
    ) u_ram (
        .wclk    (wclk),
        .wr_go   (wr_go),
        .waddr   (waddr),
        .wdata   (wdata),
        .rclk    (rclk),
        .rrst    (rrst),
        .rd_go   (rd_go),
        .raddr   (raddr),
        .rdata   (rdata),
        .rvalid  (rvalid)
    );

    // thresholds and status
    rdf_cfg_regs #(
        .DEPTH_W      (DEPTH_W)
    ) u_cfg_regs (
        .rclk         (rclk),
        .rrst         (rrst),
        .reg_we       (reg_we),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .rd_underflow (rd_underflow),
        .cfg          (cfg)
    );

endmodule

// File: tb_rdf.sv
`timescale 1ns/1ps

module tb_rdf #(
    parameter logic [31:0] SEED = 32'hf1cf_fba1
);

    import rdf_pkg::*;

    localparam int TMO    = 200;   // cycle limit of every wait loop
    localparam int AE_DEF = 2;     // reset thresholds of the reg block
    localparam int AF_DEF = 14;

    logic          wclk = 1'b0;
    logic          rclk = 1'b0;
    logic          wrst;
    logic          rrst;
    logic          w_en;
    rdf_data_t     wdata;
    logic          wfull;
    logic          almost_full;
    rdf_level_t    wr_level;
    logic          r_en;
    rdf_data_t     rdata;
    logic          rvalid;
    logic          rempty;
    logic          almost_empty;
    rdf_level_t    rd_level;
    logic          reg_we;
    rdf_reg_addr_e reg_addr;
    rdf_level_t    reg_wdata;
    rdf_level_t    reg_rdata;

    integer        seed;
    int            errors;
    int            checks;
    rdf_data_t     model_q[$];   // words stored and not yet read

    always #2 rclk = ~rclk;      // 4 ns
    always #3 wclk = ~wclk;      // 6 ns, own phase

    rdf_top #(
        .DEPTH_W      (DEPTH_W),
        .DATA_W       (DATA_W)
    ) u_rdf_top (
        .wclk         (wclk),
        .wrst         (wrst),
        .w_en         (w_en),
        .wdata        (wdata),
        .wfull        (wfull),
        .almost_full  (almost_full),
        .wr_level     (wr_level),
        .rclk         (rclk),
        .rrst         (rrst),
        .r_en         (r_en),
        .rdata        (rdata),
        .rvalid       (rvalid),
        .rempty       (rempty),
        .almost_empty (almost_empty),
        .rd_level     (rd_level),
        .reg_we       (reg_we),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata)
    );

    // *******************************************************************
    // helpers
    // *******************************************************************

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic note_error(input string what);
        errors++;
        $display("error: %s at %0t", what, $time);
    endtask

    // one word per wclk, queued only if the FIFO will take it
    task automatic write_words(input int n);
        rdf_data_t d;
        for (int i = 0; i < n; i++)
        begin
            @(posedge wclk);
            #1;
            d     = $random(seed);
            w_en  = 1'b1;
            wdata = d;
            if (!wfull)
                model_q.push_back(d);   // stored on the coming edge
        end
        @(posedge wclk);
        #1;                              // flags now show the last store
        w_en = 1'b0;
    endtask

    task automatic wait_not_empty();
        int n;
        n = 0;
        @(posedge rclk);
        #1;
        while (rempty && n < TMO)
        begin
            @(posedge rclk);
            #1;
            n++;
        end
        if (rempty)
            note_error("rempty never fell after the writes");
    endtask

    // rd_level unchanged for 8 rclk cycles
    task automatic wait_settled();
        rdf_level_t last;
        int         same;
        int         n;
        same = 0;
        n    = 0;
        @(posedge rclk);
        #1;
        last = rd_level;
        while (same < 8 && n < TMO)
        begin
            @(posedge rclk);
            #1;
            if (rd_level == last)
                same++;
            else
                same = 0;
            last = rd_level;
            n++;
        end
        if (same < 8)
            note_error("rd_level did not settle");
    endtask

    // read until empty, rdata checked against the queue on rvalid
    task automatic drain(input int exp);
        int got;
        int idle;
        int n;
        got  = 0;
        idle = 0;
        n    = 0;
        while (idle < 6 && n < TMO)
        begin
            @(posedge rclk);
            #1;
            n++;
            if (rvalid)
            begin
                got++;
                if (model_q.size() == 0)
                    note_error("rvalid with no word left in the model");
                else
                    check_val("rdata", rdata, model_q.pop_front());
            end
            r_en = ~rempty;                          // never read at empty
            idle = (rempty && !rvalid) ? idle + 1 : 0;
        end
        r_en = 1'b0;
        if (idle < 6)
            note_error("drain did not finish");
        check_val("read count", got, exp);
    endtask

    task automatic reg_write(input rdf_reg_addr_e a, input rdf_level_t d);
        @(posedge rclk);
        #1;
        reg_we    = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        @(posedge rclk);
        #1;
        reg_we = 1'b0;
    endtask

    task automatic reg_read(input rdf_reg_addr_e a, output rdf_level_t d);
        @(posedge rclk);
        #1;
        reg_addr = a;
        #1;
        d = reg_rdata;   // comb readback
    endtask

    // *******************************************************************
    // tests
    // *******************************************************************

    task automatic test_reset();
        @(posedge rclk);
        #1;
        check_val("rempty", 32'(rempty), 1);
        check_val("almost_empty", 32'(almost_empty), 1);
        check_val("rvalid", 32'(rvalid), 0);
        check_val("rd_level", 32'(rd_level), 0);
        @(posedge wclk);
        #1;
        check_val("wfull", 32'(wfull), 0);
        check_val("almost_full", 32'(almost_full), 0);
        check_val("wr_level", 32'(wr_level), 0);
    endtask

    task automatic test_order();
        write_words(10);
        wait_not_empty();
        drain(10);
    endtask

    task automatic test_full();
        write_words(16);
        check_val("wfull", 32'(wfull), 1);      // rises with the 16th store
        check_val("wr_level", 32'(wr_level), 16);
        write_words(1);                          // dropped
        check_val("queued words", model_q.size(), 16);
        wait_settled();
        check_val("rd_level", 32'(rd_level), 16);
        drain(16);
    endtask

    task automatic test_levels();
        int lv[3];
        lv = '{2, 3, 9};
        foreach (lv[i])
        begin
            write_words(lv[i]);
            wait_settled();
            check_val("rd_level", 32'(rd_level), lv[i]);
            check_val("almost_empty", 32'(almost_empty), 32'(lv[i] <= AE_DEF));
            @(posedge wclk);
            #1;
            check_val("wr_level", 32'(wr_level), lv[i]);
            check_val("almost_full", 32'(almost_full), 32'(lv[i] >= AF_DEF));
            drain(lv[i]);
        end
    endtask

    task automatic test_config();
        rdf_level_t rb;
        reg_write(REG_AF, rdf_level_t'(8));
        reg_read(REG_AF, rb);
        check_val("reg_rdata af", 32'(rb), 8);
        write_words(7);
        check_val("wr_level", 32'(wr_level), 7);
        check_val("almost_full", 32'(almost_full), 0);   // one below
        write_words(1);
        check_val("wr_level", 32'(wr_level), 8);
        check_val("almost_full", 32'(almost_full), 1);
        write_words(1);
        check_val("almost_full", 32'(almost_full), 1);
        wait_settled();
        drain(9);
        reg_write(REG_AF, rdf_level_t'(AF_DEF));         // back to reset value
    endtask

    task automatic test_underflow();
        rdf_level_t st;
        reg_read(REG_STATUS, st);
        check_val("status before underflow", 32'(st), 0);
        @(posedge rclk);
        #1;
        check_val("rempty", 32'(rempty), 1);
        r_en = 1'b1;                      // read at empty
        @(posedge rclk);
        #1;
        r_en = 1'b0;
        check_val("rvalid", 32'(rvalid), 0);
        @(posedge rclk);
        #1;
        check_val("rvalid", 32'(rvalid), 0);
        reg_read(REG_STATUS, st);
        check_val("status underflow", 32'(st), 1);
        reg_write(REG_STATUS, '0);        // clears the sticky bit
        reg_read(REG_STATUS, st);
        check_val("status after clear", 32'(st), 0);
    endtask

    // *******************************************************************
    // main sequence
    // *******************************************************************

    initial
    begin
        seed      = SEED;
        errors    = 0;
        checks    = 0;
        wrst      = 1'b1;
        rrst      = 1'b1;
        w_en      = 1'b0;
        wdata     = '0;
        r_en      = 1'b0;
        reg_we    = 1'b0;
        reg_addr  = REG_AF;
        reg_wdata = '0;
        fork
            begin
                repeat (2) @(posedge wclk);
                #1;
                wrst = 1'b0;
            end
            begin
                repeat (2) @(posedge rclk);
                #1;
                rrst = 1'b0;
            end
        join
        test_reset();
        test_order();
        test_full();
        test_levels();
        test_config();
        test_underflow();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule
